/* logic/cpu_config.svh */
// Processor size macros: word width, address width, register count, memory depth
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data and instruction word
`define CPU_WORD_WIDTH 16

// Word address into the external memory
`define CPU_ADDR_WIDTH 9

// General purpose registers
`define CPU_NUM_REGS 8

// External memory size in words
`define CPU_MEM_DEPTH 512

`endif

/* logic/isa_pkg.sv */
// Instruction set types: data words, opcodes, op codes, shifts, formats and the union
`include "cpu_config.svh"

package isa_pkg;

   typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
   typedef logic [`CPU_ADDR_WIDTH-1:0] addr_t;
   typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

   typedef enum logic [2:0] {
      OPC_LOAD  = 3'b011,
      OPC_STORE = 3'b100,
      OPC_ALU   = 3'b101,
      OPC_MOVE  = 3'b110,
      OPC_HALT  = 3'b111
   } opcode_e;

   // Meaning of op depends on the opcode
   typedef logic [1:0] op_t;
   localparam op_t OP_ADD     = 2'b00;
   localparam op_t OP_AND     = 2'b10;
   localparam op_t OP_MVN     = 2'b11;
   localparam op_t OP_MOV_REG = 2'b00;
   localparam op_t OP_MOV_IMM = 2'b10;
   localparam op_t OP_MEM     = 2'b00;

   typedef enum logic [1:0] {
      SH_NONE = 2'b00,
      SH_LSL  = 2'b01,
      SH_LSR  = 2'b10,
      SH_ASR  = 2'b11
   } shift_e;

   typedef struct packed {
      opcode_e  opcode;
      op_t      op;
      reg_idx_t rn;
      reg_idx_t rd;
      shift_e   sh;
      reg_idx_t rm;
   } instr_reg_t;

   typedef struct packed {
      opcode_e    opcode;
      op_t        op;
      reg_idx_t   rn;
      logic [7:0] imm8;
   } instr_imm8_t;

   typedef struct packed {
      opcode_e    opcode;
      op_t        op;
      reg_idx_t   rn;
      reg_idx_t   rd;
      logic [4:0] imm5;
   } instr_mem_t;

   // One stored word, decoded per format
   typedef union packed {
      instr_reg_t  r;
      instr_imm8_t i8;
      instr_mem_t  m;
   } instr_u;

endpackage

/* logic/control_pkg.sv */
// Control types: FSM states, ALU operations, write-back sources and memory commands
package control_pkg;

   typedef enum logic [3:0] {
      ST_FETCH,
      ST_UPDATE_PC,
      ST_DECODE,
      ST_ALU,
      ST_MOV_REG,
      ST_MOV_IMM,
      ST_MEM_ADDR,
      ST_LD_WAIT,
      ST_LD_WRITE,
      ST_ST_WRITE,
      ST_HALT
   } cpu_state_e;

   typedef enum logic [1:0] {
      ALU_ADD    = 2'b00,
      ALU_AND    = 2'b01,
      ALU_NOT_B  = 2'b10,
      ALU_PASS_B = 2'b11
   } alu_op_e;

   typedef enum logic [1:0] {
      WB_ALU  = 2'b00,
      WB_IMM8 = 2'b01,
      WB_MEM  = 2'b10
   } wb_sel_e;

   // Encodings seen on the memory command port
   typedef enum logic [1:0] {
      MEM_WRITE = 2'b00,
      MEM_READ  = 2'b01
   } mem_cmd_e;

endpackage

/* logic/cpu_ctrl_if.sv */
// Control interfaces from the controller: dp_ctrl_if to the datapath, fetch_ctrl_if to fetch
`timescale 1ns/1ps

interface dp_ctrl_if
   import isa_pkg::*, control_pkg::*;
();
   reg_idx_t read_a;
   reg_idx_t read_b;
   reg_idx_t write_num;
   logic     write_en;
   logic     zero_a;
   logic     imm_b;
   shift_e   shift;
   alu_op_e  alu_op;
   wb_sel_e  wb_sel;

   modport controller (output read_a, read_b, write_num, write_en, zero_a, imm_b,
                       shift, alu_op, wb_sel);
   modport datapath (input read_a, read_b, write_num, write_en, zero_a, imm_b,
                     shift, alu_op, wb_sel);
endinterface

interface fetch_ctrl_if;
   logic load_pc;
   logic load_ir;
   logic load_addr;
   // PC on the memory bus when set, data address otherwise
   logic addr_from_pc;

   modport controller (output load_pc, load_ir, load_addr, addr_from_pc);
   modport fetch (input load_pc, load_ir, load_addr, addr_from_pc);
endinterface

/* logic/register_file.sv */
// Register file: eight words, two asynchronous read ports and one synchronous write port
`timescale 1ns/1ps
`include "cpu_config.svh"

module register_file
   import isa_pkg::*;
(
   input  logic     clk,
   input  logic     write_en,
   input  reg_idx_t write_num,
   input  word_t    write_data,
   input  reg_idx_t read_a,
   input  reg_idx_t read_b,
   output word_t    data_a,
   output word_t    data_b
);

   word_t regs [`CPU_NUM_REGS];

   always_ff @(posedge clk) begin
      if (write_en) begin
         regs[write_num] <= write_data;
      end
   end

   assign data_a = regs[read_a];
   assign data_b = regs[read_b];

endmodule

/* logic/fetch_unit.sv */
// Fetch unit: program counter, instruction register, data address register, address select
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_unit
   import isa_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   fetch_ctrl_if.fetch  ctrl,
   input  word_t        read_data,
   input  word_t        result,
   output instr_u       instr,
   output addr_t        mem_addr
);

   addr_t pc;
   addr_t data_addr;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (ctrl.load_pc) begin
         pc <= pc + 1'b1;
      end
   end

   // Word fetched in the previous cycle
   always_ff @(posedge clk) begin
      if (ctrl.load_ir) begin
         instr <= read_data;
      end
   end

   // Load and store address from the datapath
   always_ff @(posedge clk) begin
      if (ctrl.load_addr) begin
         data_addr <= result[`CPU_ADDR_WIDTH-1:0];
      end
   end

   assign mem_addr = ctrl.addr_from_pc ? pc : data_addr;

endmodule

/* logic/cpu_controller.sv */
// Multicycle controller FSM: decode, datapath and fetch controls, memory command, halt
`timescale 1ns/1ps

module cpu_controller
   import isa_pkg::*, control_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  instr_u                  instr,
   fetch_ctrl_if.controller        fctrl,
   dp_ctrl_if.controller           dctrl,
   output mem_cmd_e                mem_cmd,
   output logic                    halt
);

   cpu_state_e state;
   cpu_state_e next_state;
   instr_reg_t ir;

   assign ir = instr.r;

   // Anything not recognised here halts, CMP included
   function automatic cpu_state_e decode_state(instr_reg_t word);
      cpu_state_e st;
      st = ST_HALT;
      case (word.opcode)
         OPC_MOVE: begin
            if (word.op == OP_MOV_IMM) begin
               st = ST_MOV_IMM;
            end else if (word.op == OP_MOV_REG) begin
               st = ST_MOV_REG;
            end
         end
         OPC_ALU: begin
            if (word.op == OP_ADD || word.op == OP_AND || word.op == OP_MVN) begin
               st = ST_ALU;
            end
         end
         OPC_LOAD, OPC_STORE: begin
            if (word.op == OP_MEM) begin
               st = ST_MEM_ADDR;
            end
         end
         default: st = ST_HALT;
      endcase
      return st;
   endfunction

   function automatic alu_op_e alu_op_of(op_t op);
      case (op)
         OP_AND:  return ALU_AND;
         OP_MVN:  return ALU_NOT_B;
         default: return ALU_ADD;
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_FETCH;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      case (state)
         ST_FETCH:     next_state = ST_UPDATE_PC;
         ST_UPDATE_PC: next_state = ST_DECODE;
         ST_DECODE:    next_state = decode_state(ir);
         ST_MEM_ADDR:  next_state = (ir.opcode == OPC_LOAD) ? ST_LD_WAIT : ST_ST_WRITE;
         ST_LD_WAIT:   next_state = ST_LD_WRITE;
         ST_ALU, ST_MOV_REG, ST_MOV_IMM, ST_LD_WRITE, ST_ST_WRITE: begin
            next_state = ST_FETCH;
         end
         // Stays here until reset
         default:      next_state = ST_HALT;
      endcase
   end

   always_comb begin
      dctrl.read_a       = ir.rn;
      dctrl.read_b       = ir.rm;
      dctrl.write_num    = ir.rd;
      dctrl.write_en     = 1'b0;
      dctrl.zero_a       = 1'b0;
      dctrl.imm_b        = 1'b0;
      dctrl.shift        = SH_NONE;
      dctrl.alu_op       = ALU_PASS_B;
      dctrl.wb_sel       = WB_ALU;
      fctrl.load_pc      = 1'b0;
      fctrl.load_ir      = 1'b0;
      fctrl.load_addr    = 1'b0;
      fctrl.addr_from_pc = 1'b1;
      mem_cmd            = MEM_READ;

      case (state)
         ST_UPDATE_PC: begin
            fctrl.load_ir = 1'b1;
            fctrl.load_pc = 1'b1;
         end
         ST_ALU: begin
            dctrl.shift    = ir.sh;
            dctrl.alu_op   = alu_op_of(ir.op);
            dctrl.write_en = 1'b1;
         end
         ST_MOV_REG: begin
            dctrl.zero_a   = 1'b1;
            dctrl.shift    = ir.sh;
            dctrl.write_en = 1'b1;
         end
         ST_MOV_IMM: begin
            dctrl.write_num = ir.rn;
            dctrl.wb_sel    = WB_IMM8;
            dctrl.write_en  = 1'b1;
         end
         // Rn plus imm5 into the data address register
         ST_MEM_ADDR: begin
            dctrl.imm_b     = 1'b1;
            dctrl.alu_op    = ALU_ADD;
            fctrl.load_addr = 1'b1;
         end
         ST_LD_WAIT: begin
            fctrl.addr_from_pc = 1'b0;
         end
         ST_LD_WRITE: begin
            dctrl.wb_sel   = WB_MEM;
            dctrl.write_en = 1'b1;
         end
         ST_ST_WRITE: begin
            dctrl.read_b       = ir.rd;
            dctrl.zero_a       = 1'b1;
            fctrl.addr_from_pc = 1'b0;
            mem_cmd            = MEM_WRITE;
         end
         default: begin
         end
      endcase
   end

   assign halt = (state == ST_HALT);

endmodule

/* logic/cpu_datapath.sv */
// Datapath: operand select, shifter, ALU and write-back select around the register file
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_datapath
   import isa_pkg::*, control_pkg::*;
(
   input  logic               clk,
   input  instr_u             instr,
   dp_ctrl_if.datapath        ctrl,
   input  word_t              read_data,
   output word_t              result
);

   word_t data_a;
   word_t data_b;
   word_t operand_a;
   word_t shifted_b;
   word_t operand_b;
   word_t sximm5;
   word_t sximm8;
   word_t wb_data;

   register_file u_register_file (
      .clk        (clk),
      .write_en   (ctrl.write_en),
      .write_num  (ctrl.write_num),
      .write_data (wb_data),
      .read_a     (ctrl.read_a),
      .read_b     (ctrl.read_b),
      .data_a     (data_a),
      .data_b     (data_b)
   );

   assign sximm5 = {{(`CPU_WORD_WIDTH-5){instr.m.imm5[4]}}, instr.m.imm5};
   assign sximm8 = {{(`CPU_WORD_WIDTH-8){instr.i8.imm8[7]}}, instr.i8.imm8};

   always_comb begin
      case (ctrl.shift)
         SH_LSL:  shifted_b = data_b << 1;
         SH_LSR:  shifted_b = data_b >> 1;
         SH_ASR:  shifted_b = $signed(data_b) >>> 1;
         default: shifted_b = data_b;
      endcase
   end

   assign operand_a = ctrl.zero_a ? '0 : data_a;
   assign operand_b = ctrl.imm_b ? sximm5 : shifted_b;

   always_comb begin
      case (ctrl.alu_op)
         ALU_ADD:   result = operand_a + operand_b;
         ALU_AND:   result = operand_a & operand_b;
         ALU_NOT_B: result = ~operand_b;
         default:   result = operand_b;
      endcase
   end

   always_comb begin
      case (ctrl.wb_sel)
         WB_IMM8: wb_data = sximm8;
         WB_MEM:  wb_data = read_data;
         default: wb_data = result;
      endcase
   end

endmodule

/* logic/cpu_top.sv */
// Processor top level: fetch unit, controller and datapath on a fixed-latency memory port
`timescale 1ns/1ps

module cpu_top
   import isa_pkg::*, control_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   output mem_cmd_e mem_cmd,
   output addr_t    mem_addr,
   input  word_t    read_data,
   output word_t    write_data,
   output logic     halt
);

   instr_u instr;
   word_t  result;

   fetch_ctrl_if fetch_ctrl ();
   dp_ctrl_if    dp_ctrl ();

   fetch_unit u_fetch_unit (
      .clk       (clk),
      .reset     (reset),
      .ctrl      (fetch_ctrl.fetch),
      .read_data (read_data),
      .result    (result),
      .instr     (instr),
      .mem_addr  (mem_addr)
   );

   cpu_controller u_cpu_controller (
      .clk     (clk),
      .reset   (reset),
      .instr   (instr),
      .fctrl   (fetch_ctrl.controller),
      .dctrl   (dp_ctrl.controller),
      .mem_cmd (mem_cmd),
      .halt    (halt)
   );

   cpu_datapath u_cpu_datapath (
      .clk       (clk),
      .instr     (instr),
      .ctrl      (dp_ctrl.datapath),
      .read_data (read_data),
      .result    (result)
   );

   // Store data is the datapath result
   assign write_data = result;

endmodule

/* tests/tb_clock.sv */
// Testbench clock and reset generator: 20 ns clock, reset held for a fixed number of cycles
`timescale 1ns/1ps

module tb_clock #(
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk   = 1'b0;
      reset = 1'b1;
   end

   always #10 clk = ~clk;

   // Reset changes on the falling edge, like every other DUT input
   task run_reset();
      reset = 1'b1;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
   endtask

endmodule

/* tests/cpu_sva.sv */
// Concurrent assertions on the processor memory port and halt, bound into cpu_top
`timescale 1ns/1ps

module cpu_sva
   import isa_pkg::*, control_pkg::*;
(
   input logic     clk,
   input logic     reset,
   input mem_cmd_e mem_cmd,
   input addr_t    mem_addr,
   input logic     halt
);

   // Number of failed assertions
   int error_count = 0;

   halt_sticky: assert property (@(posedge clk) disable iff (reset) halt |=> halt)
      else begin
         $error("halt dropped without a reset");
         error_count++;
      end

   write_not_back_to_back: assert property (@(posedge clk) disable iff (reset)
      (mem_cmd == MEM_WRITE) |=> (mem_cmd != MEM_WRITE))
      else begin
         $error("memory write in two consecutive cycles");
         error_count++;
      end

   read_after_reset: assert property (@(posedge clk)
      reset |=> (mem_cmd == MEM_READ && !halt))
      else begin
         $error("memory port not idle in the cycle after reset");
         error_count++;
      end

   addr_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(mem_addr))
      else begin
         $error("memory address is unknown");
         error_count++;
      end

endmodule

bind cpu_top cpu_sva u_cpu_sva (
   .clk      (clk),
   .reset    (reset),
   .mem_cmd  (mem_cmd),
   .mem_addr (mem_addr),
   .halt     (halt)
);

/* tests/tb_cpu.sv */
// Processor testbench: memory model, program table, run loop, checks and timeout
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu
   import isa_pkg::*, control_pkg::*;
();

   localparam int NUM_TESTS     = 16;
   localparam int RESET_CYCLES  = 16;
   localparam int TIMEOUT_LIMIT = NUM_TESTS * 60 + NUM_TESTS * RESET_CYCLES;
   localparam addr_t DATA0_ADDR = 9'h080;
   localparam addr_t DATA1_ADDR = 9'h081;
   localparam word_t HALT_WORD  = 16'hE000;

   logic     clk;
   logic     reset;
   mem_cmd_e mem_cmd;
   addr_t    mem_addr;
   word_t    read_data;
   word_t    write_data;
   logic     halt;

   word_t mem [`CPU_MEM_DEPTH];
   word_t read_q;
   logic  store_seen;
   addr_t store_addr;
   word_t store_val;
   int    late_writes;
   int    cycles;

   string test_name [NUM_TESTS];
   word_t prog [NUM_TESTS][8];
   word_t data0 [NUM_TESTS];
   word_t data1 [NUM_TESTS];
   logic  exp_store [NUM_TESTS];
   addr_t exp_addr [NUM_TESTS];
   word_t exp_val [NUM_TESTS];
   int    cur;
   int    slot;
   integer seed;

   tb_clock #(.RESET_CYCLES(RESET_CYCLES)) u_clock (.clk(clk), .reset(reset));

   cpu_top u_cpu_top (
      .clk        (clk),
      .reset      (reset),
      .mem_cmd    (mem_cmd),
      .mem_addr   (mem_addr),
      .read_data  (read_data),
      .write_data (write_data),
      .halt       (halt)
   );

   // Memory samples the port on the rising edge, read data appears at the falling edge
   always @(posedge clk) begin
      read_q <= mem[mem_addr];
      if (mem_cmd == MEM_WRITE) begin
         mem[mem_addr] <= write_data;
      end
      if (reset) begin
         store_seen  <= 1'b0;
         late_writes <= 0;
      end else if (mem_cmd == MEM_WRITE) begin
         if (halt) begin
            late_writes <= late_writes + 1;
         end
         if (!store_seen) begin
            store_seen <= 1'b1;
            store_addr <= mem_addr;
            store_val  <= write_data;
         end
      end
   end

   always @(negedge clk) begin
      read_data <= read_q;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_LIMIT) begin
         $display("timeout: the processor did not finish the tests in %0d cycles", cycles);
         $display("Verification failed");
         $fatal(1);
      end
   end

   always @(negedge clk) begin
      if (u_cpu_top.u_cpu_sva.error_count != 0) begin
         $display("a concurrent assertion on the memory port or halt failed");
         $display("Verification failed");
         $fatal(1);
      end
   end

   function automatic word_t enc_mov_imm(reg_idx_t rn, logic [7:0] imm8);
      return {3'b110, 2'b10, rn, imm8};
   endfunction

   function automatic word_t enc_mov_reg(reg_idx_t rd, reg_idx_t rm, shift_e sh);
      return {3'b110, 2'b00, 3'b000, rd, sh, rm};
   endfunction

   function automatic word_t enc_alu(op_t op, reg_idx_t rd, reg_idx_t rn, reg_idx_t rm,
                                     shift_e sh);
      return {3'b101, op, rn, rd, sh, rm};
   endfunction

   function automatic word_t enc_mem(opcode_e opc, reg_idx_t rd, reg_idx_t rn,
                                     logic [4:0] imm5);
      return {opc, 2'b00, rn, rd, imm5};
   endfunction

   function automatic word_t sext8(logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   task new_test(string name, logic store, addr_t addr, word_t val);
      cur = cur + 1;
      slot = 0;
      test_name[cur] = name;
      exp_store[cur] = store;
      exp_addr[cur]  = addr;
      exp_val[cur]   = val;
      data0[cur]     = 16'h0000;
      data1[cur]     = 16'h0000;
      for (int k = 0; k < 8; k++) begin
         prog[cur][k] = HALT_WORD;
      end
   endtask

   task put(word_t w);
      prog[cur][slot] = w;
      slot = slot + 1;
   endtask

   task build_table();
      logic [7:0] ra;
      logic [7:0] rb;
      cur = -1;
      new_test("mov_imm_pos", 1'b1, 9'h043, 16'h0035);
      put(enc_mov_imm(1, 8'h35));
      put(enc_mov_imm(2, 8'h40));
      put(enc_mem(OPC_STORE, 1, 2, 5'd3));
      new_test("mov_imm_neg", 1'b1, 9'h04E, 16'hFF9C);
      put(enc_mov_imm(1, 8'h9C));
      put(enc_mov_imm(2, 8'h50));
      put(enc_mem(OPC_STORE, 1, 2, 5'b11110));
      new_test("add", 1'b1, 9'h020, 16'h000C);
      put(enc_mov_imm(1, 8'h05));
      put(enc_mov_imm(2, 8'h07));
      put(enc_alu(OP_ADD, 3, 1, 2, SH_NONE));
      put(enc_mov_imm(4, 8'h20));
      put(enc_mem(OPC_STORE, 3, 4, 5'd0));
      new_test("add_lsl", 1'b1, 9'h020, 16'h0013);
      put(enc_mov_imm(1, 8'h05));
      put(enc_mov_imm(2, 8'h07));
      put(enc_alu(OP_ADD, 3, 1, 2, SH_LSL));
      put(enc_mov_imm(4, 8'h20));
      put(enc_mem(OPC_STORE, 3, 4, 5'd0));
      new_test("and", 1'b1, 9'h021, 16'h0028);
      put(enc_mov_imm(1, 8'h6C));
      put(enc_mov_imm(2, 8'h3A));
      put(enc_alu(OP_AND, 3, 1, 2, SH_NONE));
      put(enc_mov_imm(4, 8'h20));
      put(enc_mem(OPC_STORE, 3, 4, 5'd1));
      new_test("mvn", 1'b1, 9'h022, 16'hFFF0);
      put(enc_mov_imm(2, 8'h0F));
      put(enc_alu(OP_MVN, 3, 0, 2, SH_NONE));
      put(enc_mov_imm(4, 8'h20));
      put(enc_mem(OPC_STORE, 3, 4, 5'd2));
      new_test("mov_none", 1'b1, 9'h030, 16'hFF81);
      put(enc_mov_imm(2, 8'h81));
      put(enc_mov_reg(3, 2, SH_NONE));
      put(enc_mov_imm(4, 8'h30));
      put(enc_mem(OPC_STORE, 3, 4, 5'd0));
      new_test("mov_lsl", 1'b1, 9'h030, 16'hFF02);
      put(enc_mov_imm(2, 8'h81));
      put(enc_mov_reg(3, 2, SH_LSL));
      put(enc_mov_imm(4, 8'h30));
      put(enc_mem(OPC_STORE, 3, 4, 5'd0));
      new_test("mov_lsr", 1'b1, 9'h030, 16'h7FC0);
      put(enc_mov_imm(2, 8'h81));
      put(enc_mov_reg(3, 2, SH_LSR));
      put(enc_mov_imm(4, 8'h30));
      put(enc_mem(OPC_STORE, 3, 4, 5'd0));
      new_test("mov_asr", 1'b1, 9'h030, 16'hFFC0);
      put(enc_mov_imm(2, 8'h81));
      put(enc_mov_reg(3, 2, SH_ASR));
      put(enc_mov_imm(4, 8'h30));
      put(enc_mem(OPC_STORE, 3, 4, 5'd0));
      new_test("ldr_str", 1'b1, 9'h084, 16'hA5C3);
      data0[cur] = 16'hA5C3;
      put(enc_mov_imm(1, 8'h7F));
      put(enc_mem(OPC_LOAD, 2, 1, 5'd1));
      put(enc_mem(OPC_STORE, 2, 1, 5'd5));
      new_test("ldr_add", 1'b1, 9'h085, 16'h2143);
      data0[cur] = 16'h1234;
      data1[cur] = 16'h0F0F;
      put(enc_mov_imm(1, 8'h7F));
      put(enc_mem(OPC_LOAD, 2, 1, 5'd1));
      put(enc_mem(OPC_LOAD, 3, 1, 5'd2));
      put(enc_alu(OP_ADD, 4, 2, 3, SH_NONE));
      put(enc_mem(OPC_STORE, 4, 1, 5'd6));
      new_test("halt", 1'b0, 9'h000, 16'h0000);
      put(HALT_WORD);
      new_test("cmp_illegal", 1'b0, 9'h000, 16'h0000);
      put(enc_mov_imm(1, 8'h01));
      put(enc_alu(2'b01, 0, 1, 1, SH_NONE));
      put(enc_mov_imm(4, 8'h20));
      put(enc_mem(OPC_STORE, 1, 4, 5'd0));
      for (int n = 0; n < 2; n++) begin
         ra = $random(seed);
         rb = $random(seed);
         new_test(n == 0 ? "random_add_0" : "random_add_1", 1'b1, 9'h031,
                  sext8(ra) + sext8(rb));
         put(enc_mov_imm(1, ra));
         put(enc_mov_imm(2, rb));
         put(enc_alu(OP_ADD, 3, 1, 2, SH_NONE));
         put(enc_mov_imm(4, 8'h30));
         put(enc_mem(OPC_STORE, 3, 4, 5'd1));
      end
   endtask

   task load_memory(int t);
      addr_t a;
      for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
         a = i;
         mem[i] = {a[6:0], a};
      end
      for (int k = 0; k < 8; k++) begin
         mem[k] = prog[t][k];
      end
      mem[DATA0_ADDR] = data0[t];
      mem[DATA1_ADDR] = data1[t];
   endtask

   task run_test(int t);
      load_memory(t);
      u_clock.run_reset();
      #1;
      assert (halt == 1'b0 && mem_cmd == MEM_READ && mem_addr == 9'h000) else begin
         $display("error %s: expected idle port at address 000, got halt %b cmd %b addr %h",
                  test_name[t], halt, mem_cmd, mem_addr);
         $display("Verification failed");
         $fatal(1);
      end
      while (!halt) begin
         @(negedge clk);
      end
      for (int c = 0; c < 20; c++) begin
         @(negedge clk);
         assert (halt) else begin
            $display("%s: halt fell %0d cycles after it rose", test_name[t], c + 1);
            $display("Verification failed");
            $fatal(1);
         end
      end
      assert (late_writes == 0) else begin
         $display("%s: memory write issued while halted", test_name[t]);
         $display("Verification failed");
         $fatal(1);
      end
      assert (store_seen == exp_store[t]) else begin
         $display("error %s: expected store %b, actual %b", test_name[t], exp_store[t],
                  store_seen);
         $display("Verification failed");
         $fatal(1);
      end
      if (exp_store[t]) begin
         assert (store_addr == exp_addr[t]) else begin
            $display("error %s: expected address %h, actual %h", test_name[t], exp_addr[t],
                     store_addr);
            $display("Verification failed");
            $fatal(1);
         end
         assert (store_val == exp_val[t]) else begin
            $display("error %s: expected value %h, actual %h", test_name[t], exp_val[t],
                     store_val);
            $display("Verification failed");
            $fatal(1);
         end
      end
   endtask

   initial begin
      read_data = '0;
      read_q    = '0;
      cycles    = 0;
      seed      = 32'h5b84b271;
      build_table();
      for (int t = 0; t < NUM_TESTS; t++) begin
         run_test(t);
      end
      if (u_cpu_top.u_cpu_sva.error_count == 0) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("a concurrent assertion on the memory port or halt failed");
         $display("Verification failed");
         $fatal(1);
      end
   end

endmodule

/* project.f */
+incdir+logic
logic/isa_pkg.sv
logic/control_pkg.sv
logic/cpu_ctrl_if.sv
logic/register_file.sv
logic/fetch_unit.sv
logic/cpu_controller.sv
logic/cpu_datapath.sv
logic/cpu_top.sv
tests/tb_clock.sv
tests/cpu_sva.sv
tests/tb_cpu.sv

/* Bender.yml */
package:
  name: cpu16

export_include_dirs:
  - logic

sources:
  - logic/isa_pkg.sv
  - logic/control_pkg.sv
  - logic/cpu_ctrl_if.sv
  - logic/register_file.sv
  - logic/fetch_unit.sv
  - logic/cpu_controller.sv
  - logic/cpu_datapath.sv
  - logic/cpu_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/cpu_sva.sv
      - tests/tb_cpu.sv
